/* design/eeprom_pkg.sv */
package eeprom_pkg;

    // 24C16 style part, 2K bytes in eight 256-byte blocks
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    // device type code, upper nibble of the control byte
    localparam logic [3:0] CTRL_CODE = 4'b1010;

    // one operation handed from sequencer to bit engine
    typedef enum logic [1:0]
    {
        OP_START = 2'd0, // repeated start when bus not idle
        OP_STOP  = 2'd1,
        OP_WRITE = 2'd2, // 8 bits out, ack in
        OP_READ  = 2'd3  // 8 bits in, ack out
    } bit_op_e;

    // main transfer FSM
    typedef enum logic [3:0]
    {
        IDLE     = 4'd0,
        WR_START = 4'd1,
        WR_CTRL  = 4'd2,
        WR_ADDR  = 4'd3,
        WR_DATA  = 4'd4,
        RD_START = 4'd5,
        RD_CTRL  = 4'd6,
        RD_DATA  = 4'd7,
        STOP     = 4'd8,
        DONE     = 4'd9
    } seq_state_e;

    // a read is write-addressed first, then
    // repeated start and control byte with R/W = 1
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

endpackage

/* design/i2c_bit_engine.sv */
`timescale 1ns/1ps

module i2c_bit_engine #(
    parameter int CLK_DIV = 4
) (
    input  logic                              CLK,
    input  logic                              RESET,
    input  eeprom_pkg::bit_op_e               op,
    input  logic                              op_valid,
    input  logic [eeprom_pkg::DATA_W-1:0]     tx_byte,
    input  logic                              rx_last,
    output logic                              busy,
    output logic                              done,
    output logic [eeprom_pkg::DATA_W-1:0]     rx_byte,
    output logic                              nack,
    output logic                              scl,
    inout  wire                               sda
);

    localparam int QW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [QW-1:0] Q_LAST = QW'(CLK_DIV - 1);
    localparam logic [2:0] BIT_TOP = 3'(eeprom_pkg::DATA_W - 1);

    eeprom_pkg::bit_op_e op_q;

    logic [QW-1:0]                  qcnt;     // CLK cycles within a quarter
    logic [1:0]                     phase;    // quarter within a bit
    logic [2:0]                     bit_cnt;
    logic                           ack_slot; // ninth bit
    logic [eeprom_pkg::DATA_W-1:0]  tx_sh;
    logic                           hold_scl;
    logic                           hold_sda_low;
    logic                           sda_low;
    logic                           quarter_end;
    logic                           bit_end;
    logic                           op_end;
    logic                           accept;
    logic                           sample;

    assign accept      = op_valid && !busy;
    assign quarter_end = busy && (qcnt == Q_LAST);
    assign bit_end     = quarter_end && (phase == 2'd3);
    assign op_end      = bit_end && (ack_slot || op_q == eeprom_pkg::OP_START ||
                                     op_q == eeprom_pkg::OP_STOP);
    assign done        = op_end;

    // middle of SCL high
    assign sample = quarter_end && (phase == 2'd1);

    // open drain, pulled up on the board
    assign sda = sda_low ? 1'b0 : 1'bz;

    // pin levels per phase; between ops the last levels are held
    always_comb
    begin
        scl     = hold_scl;
        sda_low = hold_sda_low;
        if (busy)
        begin
            case (op_q)
                eeprom_pkg::OP_START:
                begin
                    // phase 0 releases SDA with SCL low for a repeated start
                    scl     = (phase == 2'd0) ? hold_scl : (phase != 2'd3);
                    sda_low = phase[1]; // falls while SCL high
                end
                eeprom_pkg::OP_STOP:
                begin
                    scl     = (phase != 2'd0);
                    sda_low = !phase[1]; // rises while SCL high
                end
                eeprom_pkg::OP_WRITE:
                begin
                    scl     = phase[0] ^ phase[1];
                    sda_low = ack_slot ? 1'b0 : !tx_sh[eeprom_pkg::DATA_W-1];
                end
                eeprom_pkg::OP_READ:
                begin
                    scl     = phase[0] ^ phase[1];
                    sda_low = ack_slot ? !rx_last : 1'b0; // master ack
                end
                default:
                begin
                    scl     = hold_scl;
                    sda_low = hold_sda_low;
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy         <= 1'b0;
            op_q         <= eeprom_pkg::OP_START;
            qcnt         <= '0;
            phase        <= 2'd0;
            bit_cnt      <= BIT_TOP;
            ack_slot     <= 1'b0;
            nack         <= 1'b0;
            hold_scl     <= 1'b1; // idle bus
            hold_sda_low <= 1'b0;
        end
        else if (accept)
        begin
            busy     <= 1'b1;
            op_q     <= op;
            qcnt     <= '0;
            phase    <= 2'd0;
            bit_cnt  <= BIT_TOP;
            ack_slot <= 1'b0;
            nack     <= 1'b0;
        end
        else if (busy)
        begin
            qcnt <= quarter_end ? '0 : qcnt + 1'b1;
            if (quarter_end)
            begin
                phase <= phase + 2'd1;
            end
            if (sample && ack_slot && op_q == eeprom_pkg::OP_WRITE)
            begin
                nack <= sda; // high means no ack from the slave
            end
            if (op_end)
            begin
                busy         <= 1'b0;
                hold_scl     <= scl;
                hold_sda_low <= sda_low;
            end
            else if (bit_end)
            begin
                if (bit_cnt == 3'd0)
                begin
                    ack_slot <= 1'b1;
                end
                else
                begin
                    bit_cnt <= bit_cnt - 3'd1;
                end
            end
        end
    end

    // byte shifters, MSB first
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            tx_sh <= tx_byte;
        end
        else if (bit_end && !ack_slot && op_q == eeprom_pkg::OP_WRITE)
        begin
            tx_sh <= {tx_sh[eeprom_pkg::DATA_W-2:0], 1'b0};
        end
        if (sample && !ack_slot && op_q == eeprom_pkg::OP_READ)
        begin
            rx_byte <= {rx_byte[eeprom_pkg::DATA_W-2:0], sda};
        end
    end

endmodule

/* design/eeprom_sequencer.sv */
`timescale 1ns/1ps

module eeprom_sequencer (
    input  logic                              CLK,
    input  logic                              RESET,
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [eeprom_pkg::ADDR_W-1:0]     wb_adr,
    input  logic [eeprom_pkg::DATA_W-1:0]     wb_dat_w,
    output logic [eeprom_pkg::DATA_W-1:0]     wb_dat_r,
    output logic                              wb_ack,
    output logic                              wb_err,
    output eeprom_pkg::bit_op_e               op,
    output logic                              op_valid,
    output logic [eeprom_pkg::DATA_W-1:0]     tx_byte,
    output logic                              rx_last,
    input  logic                              busy,
    input  logic                              done,
    input  logic [eeprom_pkg::DATA_W-1:0]     rx_byte,
    input  logic                              nack
);

    eeprom_pkg::seq_state_e state;

    logic                           we_q;
    logic [eeprom_pkg::ADDR_W-1:0]  adr_q;
    logic [eeprom_pkg::DATA_W-1:0]  dat_q;
    logic                           nack_seen; // sticky for the transfer
    logic                           start_req;
    logic [2:0]                     block;

    assign start_req = (state == eeprom_pkg::IDLE) && wb_cyc && wb_stb && !busy;
    assign block     = adr_q[eeprom_pkg::ADDR_W-1 -: 3];

    // one op per state, launched by op_valid on state entry
    always_comb
    begin
        case (state)
            eeprom_pkg::WR_START, eeprom_pkg::RD_START: op = eeprom_pkg::OP_START;
            eeprom_pkg::RD_DATA:                        op = eeprom_pkg::OP_READ;
            eeprom_pkg::STOP:                           op = eeprom_pkg::OP_STOP;
            default:                                    op = eeprom_pkg::OP_WRITE;
        endcase
    end

    always_comb
    begin
        case (state)
            eeprom_pkg::WR_CTRL:
                tx_byte = {eeprom_pkg::CTRL_CODE, block, eeprom_pkg::RW_WRITE};
            eeprom_pkg::RD_CTRL:
                tx_byte = {eeprom_pkg::CTRL_CODE, block, eeprom_pkg::RW_READ};
            eeprom_pkg::WR_ADDR:
                tx_byte = adr_q[7:0];
            eeprom_pkg::WR_DATA:
                tx_byte = dat_q;
            default:
                tx_byte = '0;
        endcase
    end

    assign rx_last = (state == eeprom_pkg::RD_DATA); // single byte, always nack

    assign wb_ack = (state == eeprom_pkg::DONE) && wb_cyc && wb_stb && !nack_seen;
    assign wb_err = (state == eeprom_pkg::DONE) && wb_cyc && wb_stb && nack_seen;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::IDLE;
            op_valid  <= 1'b0;
            we_q      <= 1'b0;
            nack_seen <= 1'b0;
        end
        else
        begin
            op_valid <= 1'b0;
            case (state)
                eeprom_pkg::IDLE:
                begin
                    if (start_req)
                    begin
                        we_q      <= wb_we;
                        nack_seen <= 1'b0;
                        op_valid  <= 1'b1;
                        state     <= eeprom_pkg::WR_START;
                    end
                end
                eeprom_pkg::WR_START:
                begin
                    if (done)
                    begin
                        op_valid <= 1'b1;
                        state    <= eeprom_pkg::WR_CTRL;
                    end
                end
                eeprom_pkg::WR_CTRL, eeprom_pkg::RD_CTRL:
                begin
                    if (done)
                    begin
                        op_valid <= 1'b1;
                        if (nack)
                        begin
                            nack_seen <= 1'b1;
                            state     <= eeprom_pkg::STOP;
                        end
                        else if (state == eeprom_pkg::WR_CTRL)
                        begin
                            state <= eeprom_pkg::WR_ADDR;
                        end
                        else
                        begin
                            state <= eeprom_pkg::RD_DATA;
                        end
                    end
                end
                eeprom_pkg::WR_ADDR:
                begin
                    if (done)
                    begin
                        op_valid <= 1'b1;
                        if (nack)
                        begin
                            nack_seen <= 1'b1;
                            state     <= eeprom_pkg::STOP;
                        end
                        else if (we_q)
                        begin
                            state <= eeprom_pkg::WR_DATA;
                        end
                        else
                        begin
                            state <= eeprom_pkg::RD_START; // repeated start
                        end
                    end
                end
                eeprom_pkg::WR_DATA:
                begin
                    if (done)
                    begin
                        op_valid  <= 1'b1;
                        nack_seen <= nack_seen | nack;
                        state     <= eeprom_pkg::STOP;
                    end
                end
                eeprom_pkg::RD_START:
                begin
                    if (done)
                    begin
                        op_valid <= 1'b1;
                        state    <= eeprom_pkg::RD_CTRL;
                    end
                end
                eeprom_pkg::RD_DATA:
                begin
                    if (done)
                    begin
                        op_valid <= 1'b1;
                        state    <= eeprom_pkg::STOP;
                    end
                end
                eeprom_pkg::STOP:
                begin
                    if (done)
                    begin
                        state <= eeprom_pkg::DONE;
                    end
                end
                eeprom_pkg::DONE:
                    state <= eeprom_pkg::IDLE; // ack or err this cycle
                default:
                    state <= eeprom_pkg::IDLE;
            endcase
        end
    end

    // request payload
    always_ff @(posedge CLK)
    begin
        if (start_req)
        begin
            adr_q <= wb_adr;
            dat_q <= wb_dat_w;
        end
        if (state == eeprom_pkg::RD_DATA && done)
        begin
            wb_dat_r <= rx_byte;
        end
    end

endmodule

/* design/eeprom_ctrl_top.sv */
`timescale 1ns/1ps

module eeprom_ctrl_top #(
    parameter int CLK_DIV = 4 // CLK cycles per quarter SCL period
) (
    input  logic                              CLK,
    input  logic                              RESET,
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [eeprom_pkg::ADDR_W-1:0]     wb_adr,
    input  logic [eeprom_pkg::DATA_W-1:0]     wb_dat_w,
    output logic [eeprom_pkg::DATA_W-1:0]     wb_dat_r,
    output logic                              wb_ack,
    output logic                              wb_err,
    output logic                              scl,
    inout  wire                               sda
);

    eeprom_pkg::bit_op_e            op;
    logic                           op_valid;
    logic [eeprom_pkg::DATA_W-1:0]  tx_byte;
    logic                           rx_last;
    logic                           busy;
    logic                           done;
    logic [eeprom_pkg::DATA_W-1:0]  rx_byte;
    logic                           nack;

    eeprom_sequencer u_seq (
        .CLK      (CLK),
        .RESET    (RESET),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wb_err   (wb_err),
        .op       (op),
        .op_valid (op_valid),
        .tx_byte  (tx_byte),
        .rx_last  (rx_last),
        .busy     (busy),
        .done     (done),
        .rx_byte  (rx_byte),
        .nack     (nack)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_engine (
        .CLK      (CLK),
        .RESET    (RESET),
        .op       (op),
        .op_valid (op_valid),
        .tx_byte  (tx_byte),
        .rx_last  (rx_last),
        .busy     (busy),
        .done     (done),
        .rx_byte  (rx_byte),
        .nack     (nack),
        .scl      (scl),
        .sda      (sda)
    );

endmodule

/* tests/eeprom_model.sv */
`timescale 1ns/1ps

module eeprom_model #(
    parameter realtime BUSY_NS = 3000.0 // internal write cycle
) (
    input  wire scl,
    inout  wire sda
);

    localparam int DEPTH = 2 ** eeprom_pkg::ADDR_W;

    logic [7:0]                     mem [0:DEPTH-1];
    logic                           drive_low;
    logic                           active;  // addressed and not in a write cycle
    logic                           sending; // read data on the bus
    logic                           rw;
    logic                           mnack;
    logic                           wrote;
    logic [2:0]                     blk;
    logic [7:0]                     sh;
    logic [7:0]                     tx;
    logic [7:0]                     wr_data;
    logic [eeprom_pkg::ADDR_W-1:0]  ptr;
    int                             cnt;     // SCL rising edges within the byte
    int                             byte_n;
    realtime                        busy_until;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < DEPTH; i++)
        begin
            mem[i] = 8'hFF;
        end
        drive_low  = 1'b0;
        active     = 1'b0;
        sending    = 1'b0;
        wrote      = 1'b0;
        busy_until = 0.0;
    end

    // full byte received, decide on the ack
    task automatic take_byte();
        logic ok;
        ok = 1'b1;
        case (byte_n)
            0:
            begin
                ok = (sh[7:4] == eeprom_pkg::CTRL_CODE);
                rw = sh[0];
                if (sh[0])
                    ptr = {sh[3:1], ptr[7:0]}; // block bits pick the page again
                else
                    blk = sh[3:1];
            end
            1: ptr = {blk, sh};
            2:
            begin
                wr_data = sh;
                wrote   = 1'b1;
            end
            default: ok = 1'b0; // no page writes
        endcase
        byte_n    = byte_n + 1;
        active    = ok;
        drive_low = ok;
    endtask

    always @(negedge sda)
    begin
        if (scl === 1'b1) // start or repeated start
        begin
            active    = ($realtime >= busy_until);
            sending   = 1'b0;
            drive_low = 1'b0;
            rw        = 1'b0;
            wrote     = 1'b0;
            cnt       = 0;
            byte_n    = 0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1) // stop
        begin
            if (active && wrote)
            begin
                mem[ptr]   = wr_data;
                busy_until = $realtime + BUSY_NS;
            end
            active    = 1'b0;
            sending   = 1'b0;
            drive_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (active)
        begin
            if (cnt < 8 && !sending)
                sh = {sh[6:0], sda};
            else if (cnt == 8 && sending)
                mnack = sda; // master ack level
            cnt = cnt + 1;
        end
    end

    always @(negedge scl)
    begin
        if (active)
        begin
            if (cnt == 8)
            begin
                if (sending)
                    drive_low = 1'b0;
                else
                    take_byte();
            end
            else if (cnt == 9)
            begin
                cnt       = 0;
                drive_low = 1'b0;
                if (sending && mnack)
                begin
                    sending = 1'b0;
                end
                else if (rw)
                begin
                    if (sending)
                        ptr = ptr + 1'b1;
                    tx        = mem[ptr];
                    sending   = 1'b1;
                    drive_low = !tx[7];
                end
            end
            else if (sending && cnt > 0)
            begin
                drive_low = !tx[7 - cnt];
            end
        end
    end

endmodule

/* tests/eeprom_sva.sv */
`timescale 1ns/1ps

module eeprom_sva (
    input logic                 CLK,
    input logic                 RESET,
    input logic                 wb_cyc,
    input logic                 wb_stb,
    input logic                 wb_ack,
    input logic                 wb_err,
    input logic                 scl,
    input wire                  sda,
    input logic                 busy,
    input eeprom_pkg::bit_op_e  op
);

    int fail_count = 0;

    // only a start may pull sda down and only a stop may let it go under a high scl
    property sda_held_p;
        @(posedge CLK) disable iff (RESET)
            (scl && $past(scl) && sda !== $past(sda)) |->
                (busy && ((op == eeprom_pkg::OP_START && !sda) ||
                          (op == eeprom_pkg::OP_STOP && sda)));
    endproperty

    a_ack_err_excl: assert property (@(posedge CLK) disable iff (RESET)
        !(wb_ack && wb_err))
    else
    begin
        $error("wb_ack and wb_err high together");
        fail_count++;
    end

    a_resp_in_cycle: assert property (@(posedge CLK) disable iff (RESET)
        (wb_ack || wb_err) |-> (wb_cyc && wb_stb))
    else
    begin
        $error("wb_ack or wb_err outside a cycle");
        fail_count++;
    end

    a_resp_pulse: assert property (@(posedge CLK) disable iff (RESET)
        (wb_ack || wb_err) |=> !(wb_ack || wb_err))
    else
    begin
        $error("wb_ack or wb_err longer than one cycle");
        fail_count++;
    end

    a_sda_held: assert property (sda_held_p)
    else
    begin
        $error("sda moved while scl high outside start or stop");
        fail_count++;
    end

    a_idle_bus: assert property (@(posedge CLK)
        $fell(RESET) |-> (scl === 1'b1 && sda === 1'b1))
    else
    begin
        $error("bus not idle after reset");
        fail_count++;
    end

endmodule

bind eeprom_ctrl_top eeprom_sva u_sva (
    .CLK    (CLK),
    .RESET  (RESET),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .wb_err (wb_err),
    .scl    (scl),
    .sda    (sda),
    .busy   (busy),
    .op     (op)
);

/* tests/eeprom_tb.sv */
`timescale 1ns/1ps

module eeprom_tb;

    localparam int         CLK_DIV  = 4;
    localparam int         TIMEOUT  = 2000; // cycles per Wishbone cycle
    localparam int         SETTLE   = 400;  // longer than the 3000 ns write time
    localparam logic [1:0] RESP_ACK = 2'b01;
    localparam logic [1:0] RESP_ERR = 2'b10;

    logic                           CLK;
    logic                           RESET;
    logic                           wb_cyc;
    logic                           wb_stb;
    logic                           wb_we;
    logic [eeprom_pkg::ADDR_W-1:0]  wb_adr;
    logic [eeprom_pkg::DATA_W-1:0]  wb_dat_w;
    logic [eeprom_pkg::DATA_W-1:0]  wb_dat_r;
    logic                           wb_ack;
    logic                           wb_err;
    logic                           scl;
    wire                            sda;

    logic [7:0] ref_mem [0:2**eeprom_pkg::ADDR_W-1];
    int         errors;
    int         checks;

    pullup (sda);

    eeprom_ctrl_top #(
        .CLK_DIV (CLK_DIV)
    ) UUT (
        .CLK      (CLK),
        .RESET    (RESET),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wb_err   (wb_err),
        .scl      (scl),
        .sda      (sda)
    );

    eeprom_model u_eeprom (
        .scl (scl),
        .sda (sda)
    );

    always #4 CLK = ~CLK;

    function automatic string resp_name(input logic [1:0] resp);
        case (resp)
            RESP_ACK: return "ack";
            RESP_ERR: return "err";
            default:  return "none";
        endcase
    endfunction

    // inputs held until ack or err, stb dropped the cycle after
    task automatic run_cycle(input logic we, input logic [10:0] adr, input logic [7:0] dat,
                             input string name, output logic [1:0] resp,
                             output logic [7:0] rdata);
        int n;
        @(posedge CLK);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        n = 0;
        while (!(wb_ack || wb_err) && n < TIMEOUT)
        begin
            @(posedge CLK);
            #1;
            n++;
        end
        resp  = {wb_err, wb_ack};
        rdata = wb_dat_r;
        if (!(wb_ack || wb_err))
        begin
            $display("%s: no ack or err from the controller within %0d cycles", name, TIMEOUT);
            errors++;
        end
        @(posedge CLK);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic verify_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            $display("ERR %s: expected %s, actual %s", name, resp_name(exp), resp_name(act));
            errors++;
        end
    endtask

    task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            $display("ERR %s: expected %02h, actual %02h", name, exp, act);
            errors++;
        end
    endtask

    task automatic write_byte(input string name, input logic [10:0] adr, input logic [7:0] dat,
                              input logic [1:0] exp_resp);
        logic [1:0] resp;
        logic [7:0] ignored;
        run_cycle(1'b1, adr, dat, name, resp, ignored);
        verify_resp(name, exp_resp, resp);
        if (exp_resp == RESP_ACK)
            ref_mem[adr] = dat;
    endtask

    task automatic read_back(input string name, input logic [10:0] adr);
        logic [1:0] resp;
        logic [7:0] rdata;
        run_cycle(1'b0, adr, 8'h00, name, resp, rdata);
        verify_resp(name, RESP_ACK, resp);
        compare_byte(name, ref_mem[adr], rdata);
    endtask

    initial
    begin
        logic [10:0] adrs [0:7];
        logic [7:0]  dat;
        void'($urandom(55));
        errors   = 0;
        checks   = 0;
        CLK      = 1'b0;
        RESET    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        for (int a = 0; a < 2**eeprom_pkg::ADDR_W; a++)
        begin
            ref_mem[a] = 8'hFF; // erased part
        end
        repeat (4) @(posedge CLK);
        #1;
        RESET = 1'b0;
        repeat (2) @(posedge CLK);

        read_back("blank read", 11'h3C5);

        write_byte("single write", 11'h123, 8'hA5, RESP_ACK);
        repeat (SETTLE) @(posedge CLK);
        read_back("single read", 11'h123);

        // one random location per block
        for (int b = 0; b < 8; b++)
        begin
            adrs[b] = {3'(b), 8'($urandom)};
            dat     = 8'($urandom);
            write_byte("block write", adrs[b], dat, RESP_ACK);
            repeat (SETTLE) @(posedge CLK);
        end
        for (int b = 0; b < 8; b++)
        begin
            read_back("block read", adrs[b]);
        end

        // second write lands inside the write time
        write_byte("busy first", 11'h6E1, 8'h3C, RESP_ACK);
        write_byte("busy second", 11'h6E1, 8'hC3, RESP_ERR);
        repeat (SETTLE) @(posedge CLK);
        read_back("busy keep", 11'h6E1);
        write_byte("busy retry", 11'h6E1, 8'hC3, RESP_ACK);
        repeat (SETTLE) @(posedge CLK);
        read_back("busy retry read", 11'h6E1);

        errors = errors + UUT.u_sva.fail_count;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* eeprom_ctrl.f */
design/eeprom_pkg.sv
design/i2c_bit_engine.sv
design/eeprom_sequencer.sv
design/eeprom_ctrl_top.sv
tests/eeprom_model.sv
tests/eeprom_sva.sv
tests/eeprom_tb.sv

/* Bender.yml */
package:
  name: eeprom_ctrl

sources:
  - design/eeprom_pkg.sv
  - design/i2c_bit_engine.sv
  - design/eeprom_sequencer.sv
  - design/eeprom_ctrl_top.sv
  - target: test
    files:
      - tests/eeprom_model.sv
      - tests/eeprom_sva.sv
      - tests/eeprom_tb.sv
